//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert -j 0
TOP       := muscle_core_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

# static checks on the whole project
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then search the log for the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/activation_filter.sv
`timescale 1ns/10ps
`default_nettype none

// spike count to activation h
// h = b1*x1 + b2*x2 - a1*y1 - a2*y2
// the current sample only enters the history, so h lags the input by one step
module activation_filter (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             step_i,
    input  wire muscle_io_pkg::muscle_in_t  in_i,
    output logic                            valid_o,
    output muscle_io_pkg::activation_t      act_o
);

    ////////////////////
    // history registers
    ////////////////////

    // previous two converted spike counts
    muscle_fix_pkg::fix_t x1_q;
    muscle_fix_pkg::fix_t x2_q;
    // previous two filter outputs
    muscle_fix_pkg::fix_t y1_q;
    muscle_fix_pkg::fix_t y2_q;

    // spike count in q16.16
    muscle_fix_pkg::fix_t x_cur;
    // individual products
    muscle_fix_pkg::fix_t t_b1;
    muscle_fix_pkg::fix_t t_b2;
    muscle_fix_pkg::fix_t t_a1;
    muscle_fix_pkg::fix_t t_a2;
    // new activation
    muscle_fix_pkg::fix_t h_next;

    ////////////////////
    // difference equation
    ////////////////////

    // integer count moved up into the integer half of the word
    assign x_cur = muscle_fix_pkg::fix_t'({in_i.spike_cnt, {muscle_fix_pkg::FRAC_BITS{1'b0}}});

    // four multipliers, one per tap
    assign t_b1 = muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_B1, x1_q);
    assign t_b2 = muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_B2, x2_q);
    assign t_a1 = muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_A1, y1_q);
    assign t_a2 = muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_A2, y2_q);

    // feedback taps subtract, sums wrap at 32 bits
    assign h_next = t_b1 + t_b2 - t_a1 - t_a2;

    ////////////////////
    // step update
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x1_q    <= '0;
            x2_q    <= '0;
            y1_q    <= '0;
            y2_q    <= '0;
            act_o   <= '0;
            valid_o <= 1'b0;
        end else begin
            // one cycle pulse per accepted step
            valid_o <= step_i;
            if (step_i) begin
                // shift input history
                x1_q <= x_cur;
                x2_q <= x1_q;
                // shift output history
                y1_q <= h_next;
                y2_q <= y1_q;
                // result travels with the kinematics of this sample
                act_o.h   <= h_next;
                act_o.pos <= in_i.pos;
                act_o.vel <= in_i.vel;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/length_weight.sv
`timescale 1ns/10ps
`default_nettype none

// force-length weighting of the activation
// the weight is a piecewise quadratic of the muscle length
module length_weight (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             act_valid_i,
    input  wire muscle_io_pkg::activation_t act_i,
    output logic                            valid_o,
    output muscle_io_pkg::active_state_t    as_o
);

    // length squared, shared by both quadratics
    muscle_fix_pkg::fix_t x_sq;
    // -4x^2 + 8x - 3 for the rising limb
    muscle_fix_pkg::fix_t w_rise;
    // -x^2 + 2x for the falling limb
    muscle_fix_pkg::fix_t w_fall;
    // selected weight
    muscle_fix_pkg::fix_t weight;

    ////////////////////
    // quadratics
    ////////////////////

    assign x_sq = muscle_fix_pkg::fix_mul(act_i.pos, act_i.pos);

    assign w_rise = muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_EIGHT, act_i.pos)
                  - muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_FOUR, x_sq)
                  - muscle_fix_pkg::W_THREE;

    assign w_fall = muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_TWO, act_i.pos) - x_sq;

    ////////////////////
    // region select
    ////////////////////

    // signed compares, a negative length falls in the first region
    always_comb begin
        if (act_i.pos <= muscle_fix_pkg::W_LO) begin
            weight = '0;
        end else if (act_i.pos <= muscle_fix_pkg::W_ONE) begin
            weight = w_rise;
        end else if (act_i.pos <= muscle_fix_pkg::W_TWO) begin
            weight = w_fall;
        end else begin
            // overstretched, no overlap left
            weight = '0;
        end
    end

    ////////////////////
    // active state register
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            as_o    <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= act_valid_i;
            if (act_valid_i) begin
                as_o.a_state <= muscle_fix_pkg::fix_mul(weight, act_i.h);
                as_o.pos     <= act_i.pos;
                as_o.vel     <= act_i.vel;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/muscle_core.sv
`timescale 1ns/10ps
`default_nettype none

// muscle model top
// three registered stages, one cycle each, three steps may be in flight
module muscle_core (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            step_i,
    input  wire muscle_io_pkg::muscle_in_t muscle_in_i,
    output logic                           force_valid_o,
    output muscle_io_pkg::force_out_t      force_o
);

    ////////////////////
    // stage links
    ////////////////////

    // filter to weighting
    logic                          act_valid;
    muscle_io_pkg::activation_t    act;

    // weighting to integrator
    logic                          as_valid;
    muscle_io_pkg::active_state_t  as_st;

    ////////////////////
    // stages
    ////////////////////

    // spike count to h
    activation_filter u_activation_filter (
        .clk     (clk),
        .reset   (reset),
        .step_i  (step_i),
        .in_i    (muscle_in_i),
        .valid_o (act_valid),
        .act_o   (act)
    );

    // h scaled by force-length weight
    length_weight u_length_weight (
        .clk         (clk),
        .reset       (reset),
        .act_valid_i (act_valid),
        .act_i       (act),
        .valid_o     (as_valid),
        .as_o        (as_st)
    );

    // tension derivative and accumulator
    tension_integrator u_tension_integrator (
        .clk        (clk),
        .reset      (reset),
        .as_valid_i (as_valid),
        .as_i       (as_st),
        .valid_o    (force_valid_o),
        .force_o    (force_o)
    );

endmodule

`default_nettype wire

//--- hw/muscle_fix_pkg.sv
`default_nettype none

package muscle_fix_pkg;

    ////////////////////
    // number formats
    ////////////////////

    // signed q16.16 for lengths, velocities, activations and forces
    typedef logic signed [31:0] fix_t;
    // spike count collected over one time step
    typedef logic [15:0] spike_cnt_t;

    localparam int FRAC_BITS = 16;
    // integration step of 1/1024 s
    localparam int DT_SHIFT = 10;

    ////////////////////
    // model coefficients
    ////////////////////

    // second order activation filter, truncated toward zero
    localparam fix_t COEF_B1 = 32'sd143196;
    localparam fix_t COEF_B2 = -32'sd142606;
    localparam fix_t COEF_A1 = -32'sd127270;
    localparam fix_t COEF_A2 = 32'sd61800;

    // force-length region bounds and quadratic factors
    localparam fix_t W_LO    = 32'sd32768;
    localparam fix_t W_ONE   = 32'sd65536;
    localparam fix_t W_TWO   = 32'sd131072;
    localparam fix_t W_THREE = 32'sd196608;
    localparam fix_t W_FOUR  = 32'sd262144;
    localparam fix_t W_EIGHT = 32'sd524288;

    // tension derivative terms
    localparam fix_t REST_LEN  = 32'sd65536;
    localparam fix_t K_PASSIVE = 32'sd13369344;
    localparam fix_t K_VISCOUS = 32'sd8912896;
    localparam fix_t K_DECAY   = 32'sd276561;
    localparam fix_t K_ACTIVE  = 32'sd178257;

    // full 64 bit product, floor shift by the fraction width, low 32 bits kept
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [63:0] prod;
        logic signed [63:0] scaled;
        prod   = a * b;
        scaled = prod >>> FRAC_BITS;
        return fix_t'(scaled[31:0]);
    endfunction

endpackage

`default_nettype wire

//--- hw/muscle_io_pkg.sv
`default_nettype none

package muscle_io_pkg;

    ////////////////////
    // stage samples
    ////////////////////

    // one time step as it arrives from outside
    typedef struct packed {
        muscle_fix_pkg::spike_cnt_t spike_cnt;
        muscle_fix_pkg::fix_t       pos;
        muscle_fix_pkg::fix_t       vel;
    } muscle_in_t;

    // filter output with the kinematics of the same step
    typedef struct packed {
        muscle_fix_pkg::fix_t h;
        muscle_fix_pkg::fix_t pos;
        muscle_fix_pkg::fix_t vel;
    } activation_t;

    // activation already scaled by the force-length weight
    typedef struct packed {
        muscle_fix_pkg::fix_t a_state;
        muscle_fix_pkg::fix_t pos;
        muscle_fix_pkg::fix_t vel;
    } active_state_t;

    // result handed to the outside
    typedef struct packed {
        muscle_fix_pkg::fix_t tension;
        muscle_fix_pkg::fix_t a_state;
    } force_out_t;

endpackage

`default_nettype wire

//--- hw/tension_integrator.sv
`timescale 1ns/10ps
`default_nettype none

// tension derivative and forward euler integration
// dT = 204*(x - x0)+ + 136*v - 4.22*T + 2.72*A
// T holds between steps, the only state of this stage besides the output
module tension_integrator (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               as_valid_i,
    input  wire muscle_io_pkg::active_state_t as_i,
    output logic                              valid_o,
    output muscle_io_pkg::force_out_t         force_o
);

    // stored tension, read back from the output register
    muscle_fix_pkg::fix_t tension_q;

    // length beyond rest
    muscle_fix_pkg::fix_t stretch;
    // the four derivative terms
    muscle_fix_pkg::fix_t f_passive;
    muscle_fix_pkg::fix_t f_viscous;
    muscle_fix_pkg::fix_t f_decay;
    muscle_fix_pkg::fix_t f_active;
    // derivative and its scaled step
    muscle_fix_pkg::fix_t d_tension;
    muscle_fix_pkg::fix_t d_step;
    // tension after this step
    muscle_fix_pkg::fix_t tension_next;

    assign tension_q = force_o.tension;

    ////////////////////
    // derivative
    ////////////////////

    assign stretch = as_i.pos - muscle_fix_pkg::REST_LEN;

    // slack muscle carries no passive force
    assign f_passive = stretch[31] ? '0 :
                       muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_PASSIVE, stretch);

    // damping on lengthening velocity
    assign f_viscous = muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_VISCOUS, as_i.vel);

    // relaxation toward zero
    assign f_decay = muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_DECAY, tension_q);

    // drive from the active state
    assign f_active = muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_ACTIVE, as_i.a_state);

    assign d_tension = f_passive + f_viscous - f_decay + f_active;

    ////////////////////
    // integration
    ////////////////////

    // multiply by dt as an arithmetic shift, rounds toward minus infinity
    assign d_step = d_tension >>> muscle_fix_pkg::DT_SHIFT;

    assign tension_next = tension_q + d_step;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            force_o <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= as_valid_i;
            if (as_valid_i) begin
                // accumulator and result share one register
                force_o.tension <= tension_next;
                force_o.a_state <= as_i.a_state;
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hw/muscle_fix_pkg.sv
hw/muscle_io_pkg.sv
hw/activation_filter.sv
hw/length_weight.sv
hw/tension_integrator.sv
hw/muscle_core.sv
verification/muscle_core_asserts.sv
verification/muscle_core_tb.sv

//--- verification/muscle_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the muscle pipeline
// step to result latency, quiet reset and clean output data
module muscle_core_asserts (
    input wire                            clk,
    input wire                            reset,
    input wire                            step_i,
    input wire                            act_valid_i,
    input wire                            as_valid_i,
    input wire                            force_valid_i,
    input wire muscle_io_pkg::force_out_t force_i
);

    ////////////////////
    // latency
    ////////////////////

    // each step leaves the pipe exactly three cycles later
    a_step_to_force: assert property (@(posedge clk) disable iff (reset)
        step_i |-> ##3 force_valid_i)
        else $error("force valid missing three cycles after a step");

    // no result without a step three cycles earlier
    a_force_from_step: assert property (@(posedge clk) disable iff (reset)
        force_valid_i |-> $past(step_i, 3))
        else $error("force valid without a matching step");

    ////////////////////
    // reset and data
    ////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        reset |-> (!act_valid_i && !as_valid_i && !force_valid_i && force_i == '0))
        else $error("valid or nonzero output while reset is high");

    a_force_known: assert property (@(posedge clk) disable iff (reset)
        force_valid_i |-> !$isunknown(force_i))
        else $error("unknown bits on force output while valid");

endmodule

// attached to every muscle_core instance
bind muscle_core muscle_core_asserts u_muscle_core_asserts (
    .clk           (clk),
    .reset         (reset),
    .step_i        (step_i),
    .act_valid_i   (act_valid),
    .as_valid_i    (as_valid),
    .force_valid_i (force_valid_o),
    .force_i       (force_o)
);

`default_nettype wire

//--- verification/muscle_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

// testbench for the three stage muscle pipeline
// steps come from a table, a software model predicts every result bit for bit
module muscle_core_tb;

    // one step of stimulus and the idle cycles after it
    typedef struct packed {
        muscle_fix_pkg::spike_cnt_t spike_cnt;
        muscle_fix_pkg::fix_t       pos;
        muscle_fix_pkg::fix_t       vel;
        logic [7:0]                 gap;
    } stim_entry_t;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CHECKS  = 6;
    localparam int NUM_STEPS    = 32;
    localparam int PIPE_DEPTH   = 3;
    localparam int DRAIN_LIMIT  = 32;
    localparam int QUIET_CYCLES = 10;

    // lengths in q16.16, truncated
    localparam muscle_fix_pkg::fix_t L_040 = 32'sd26214;
    localparam muscle_fix_pkg::fix_t L_080 = 32'sd52428;
    localparam muscle_fix_pkg::fix_t L_090 = 32'sd58982;
    localparam muscle_fix_pkg::fix_t L_095 = 32'sd62259;
    localparam muscle_fix_pkg::fix_t L_100 = 32'sd65536;
    localparam muscle_fix_pkg::fix_t L_110 = 32'sd72089;
    localparam muscle_fix_pkg::fix_t L_120 = 32'sd78643;
    localparam muscle_fix_pkg::fix_t L_130 = 32'sd85196;
    localparam muscle_fix_pkg::fix_t L_150 = 32'sd98304;
    localparam muscle_fix_pkg::fix_t L_250 = 32'sd163840;
    // velocities 0, 0.05 and -0.1
    localparam muscle_fix_pkg::fix_t V_ZERO = 32'sd0;
    localparam muscle_fix_pkg::fix_t V_POS  = 32'sd3276;
    localparam muscle_fix_pkg::fix_t V_NEG  = -32'sd6553;

    logic                        clk;
    logic                        reset;
    logic                        step_i;
    muscle_io_pkg::muscle_in_t   muscle_in_i;
    logic                        force_valid_o;
    muscle_io_pkg::force_out_t   force_o;

    stim_entry_t                 stim_tab [NUM_STEPS];

    // expected results and the cycle of the step that caused each one
    muscle_io_pkg::force_out_t   exp_q [$];
    int unsigned                 cyc_q [$];
    int unsigned                 cycle_cnt = 0;
    // set once a verdict line has been printed
    bit                          verdict_done = 1'b0;

    // model state, same history as the filter and the accumulator
    muscle_fix_pkg::fix_t        mdl_x1;
    muscle_fix_pkg::fix_t        mdl_x2;
    muscle_fix_pkg::fix_t        mdl_y1;
    muscle_fix_pkg::fix_t        mdl_y2;
    muscle_fix_pkg::fix_t        mdl_t;

    muscle_core u_muscle_core (
        .clk           (clk),
        .reset         (reset),
        .step_i        (step_i),
        .muscle_in_i   (muscle_in_i),
        .force_valid_o (force_valid_o),
        .force_o       (force_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // reporting
    ////////////////////

    task automatic stop_on_failure();
        verdict_done = 1'b1;
        $display("sim failed");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        // case inequality so that x or z on the DUT side is caught too
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // run stopped by a bound assertion before any verdict
    final begin
        if (!verdict_done) begin
            $display("sim failed");
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // force-length weight, zero outside 0.5 < x <= 2
    function automatic muscle_fix_pkg::fix_t weight_of(input muscle_fix_pkg::fix_t len);
        muscle_fix_pkg::fix_t len_sq;
        len_sq = muscle_fix_pkg::fix_mul(len, len);
        if (len <= muscle_fix_pkg::W_LO || len > muscle_fix_pkg::W_TWO) begin
            return '0;
        end
        if (len <= muscle_fix_pkg::W_ONE) begin
            return muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_EIGHT, len)
                 - muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_FOUR, len_sq)
                 - muscle_fix_pkg::W_THREE;
        end
        return muscle_fix_pkg::fix_mul(muscle_fix_pkg::W_TWO, len) - len_sq;
    endfunction

    // one time step through all three stages, result queued in order
    task automatic predict_step(input stim_entry_t ent);
        muscle_fix_pkg::fix_t      x_now;
        muscle_fix_pkg::fix_t      h;
        muscle_fix_pkg::fix_t      a_st;
        muscle_fix_pkg::fix_t      stretch;
        muscle_fix_pkg::fix_t      passive;
        muscle_fix_pkg::fix_t      deriv;
        muscle_io_pkg::force_out_t res;
        x_now = {ent.spike_cnt, 16'h0000};
        // h only sees past samples, the new count enters the history
        h = muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_B1, mdl_x1)
          + muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_B2, mdl_x2)
          - muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_A1, mdl_y1)
          - muscle_fix_pkg::fix_mul(muscle_fix_pkg::COEF_A2, mdl_y2);
        mdl_x2 = mdl_x1;
        mdl_x1 = x_now;
        mdl_y2 = mdl_y1;
        mdl_y1 = h;
        a_st = muscle_fix_pkg::fix_mul(weight_of(ent.pos), h);
        // passive force only when stretched past rest length
        stretch = ent.pos - muscle_fix_pkg::REST_LEN;
        passive = (stretch < 0) ? '0 : muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_PASSIVE, stretch);
        deriv = passive
              + muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_VISCOUS, ent.vel)
              - muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_DECAY, mdl_t)
              + muscle_fix_pkg::fix_mul(muscle_fix_pkg::K_ACTIVE, a_st);
        mdl_t = mdl_t + (deriv >>> muscle_fix_pkg::DT_SHIFT);
        res.tension = mdl_t;
        res.a_state = a_st;
        exp_q.push_back(res);
        cyc_q.push_back(cycle_cnt);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    // called just after a rising edge, returns just after the edge of the next step
    task automatic apply_step(input stim_entry_t ent);
        step_i = 1'b1;
        muscle_in_i.spike_cnt = ent.spike_cnt;
        muscle_in_i.pos = ent.pos;
        muscle_in_i.vel = ent.vel;
        predict_step(ent);
        @(posedge clk);
        #1;
        step_i = 1'b0;
        muscle_in_i = '0;
        repeat (ent.gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // results sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        muscle_io_pkg::force_out_t exp_res;
        int unsigned               exp_cyc;
        if (!reset && force_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("force_valid_o went high with no step outstanding");
                stop_on_failure();
            end else begin
                exp_res = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                check_value("force_valid_o cycle", cycle_cnt, exp_cyc + PIPE_DEPTH);
                check_value("force_o.tension", force_o.tension, exp_res.tension);
                check_value("force_o.a_state", force_o.a_state, exp_res.a_state);
            end
        end
    end

    initial begin
        int drain;
        step_i      = 1'b0;
        muscle_in_i = '0;
        reset       = 1'b1;
        mdl_x1      = '0;
        mdl_x2      = '0;
        mdl_y1      = '0;
        mdl_y2      = '0;
        mdl_t       = '0;
        // spike count, length, velocity, idle cycles after the step
        stim_tab = '{
            // spike burst then silence at 0.8
            '{16'd4, L_080, V_ZERO, 8'd1}, '{16'd6, L_080, V_ZERO, 8'd2},
            '{16'd8, L_080, V_ZERO, 8'd1}, '{16'd5, L_080, V_ZERO, 8'd1},
            '{16'd0, L_080, V_ZERO, 8'd1}, '{16'd0, L_080, V_ZERO, 8'd1},
            '{16'd0, L_080, V_ZERO, 8'd1}, '{16'd0, L_080, V_ZERO, 8'd1},
            '{16'd0, L_080, V_ZERO, 8'd3},
            // one step in each weight region, outer ones give zero
            '{16'd3, L_040, V_ZERO, 8'd2}, '{16'd3, L_080, V_ZERO, 8'd2},
            '{16'd3, L_150, V_ZERO, 8'd2}, '{16'd3, L_250, V_ZERO, 8'd2},
            '{16'd3, L_040, V_POS, 8'd1},  '{16'd3, L_250, V_NEG, 8'd3},
            // stretched at 1.2 then slack at 0.9
            '{16'd0, L_120, V_ZERO, 8'd1}, '{16'd0, L_120, V_ZERO, 8'd1},
            '{16'd0, L_120, V_ZERO, 8'd1}, '{16'd0, L_120, V_ZERO, 8'd1},
            '{16'd0, L_120, V_ZERO, 8'd1}, '{16'd0, L_120, V_ZERO, 8'd1},
            '{16'd0, L_090, V_ZERO, 8'd1}, '{16'd0, L_090, V_ZERO, 8'd1},
            '{16'd0, L_090, V_ZERO, 8'd1}, '{16'd0, L_090, V_ZERO, 8'd4},
            // back to back, three steps in flight
            '{16'd2, L_110, V_POS, 8'd0},  '{16'd7, L_095, V_NEG, 8'd0},
            '{16'd1, L_130, V_POS, 8'd0},  '{16'd0, L_120, V_ZERO, 8'd0},
            '{16'd9, L_080, V_NEG, 8'd0},  '{16'd3, L_150, V_POS, 8'd0},
            '{16'd0, L_100, V_ZERO, 8'd2}
        };
        // no stage may report a result while reset is high
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("act_valid", {31'd0, u_muscle_core.act_valid}, 32'd0);
            check_value("as_valid", {31'd0, u_muscle_core.as_valid}, 32'd0);
            check_value("force_valid_o", {31'd0, force_valid_o}, 32'd0);
        end
        reset = 1'b0;
        // quiet and zeroed until the first step
        repeat (IDLE_CHECKS) begin
            @(negedge clk);
            check_value("force_valid_o", {31'd0, force_valid_o}, 32'd0);
            check_value("force_o.tension", force_o.tension, 32'd0);
            check_value("force_o.a_state", force_o.a_state, 32'd0);
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(stim_tab[i]);
        end
        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(negedge clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out waiting for %0d outstanding results", exp_q.size());
            stop_on_failure();
        end
        // any late valid now hits the empty queue in the collector
        repeat (QUIET_CYCLES) @(posedge clk);
        verdict_done = 1'b1;
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
